// File: logic/mem_pkg.sv
package mem_pkg;

  // Memory geometry
  localparam int MEM_DEPTH = 32;           // Words in the data memory
  localparam int NB_ADDR   = 5;            // Word address width
  localparam int NB_DATA   = 32;           // Data word width
  localparam int NB_LANES  = 4;            // Byte lanes per word

  typedef logic [NB_ADDR-1:0]  addr_t;     // Word address
  typedef logic [NB_DATA-1:0]  word_t;     // Memory word
  typedef logic [NB_LANES-1:0] lane_mask_t; // Bit 0 is bits 7:0

  // Access size, reserved code behaves as a full word
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10,
    SIZE_RSVD = 2'b11
  } mem_size_e;

  // Request as issued by the execute stage
  typedef struct packed {
    logic      valid;
    logic      write;
    logic      read;
    mem_size_e size;
    logic      is_unsigned;
    addr_t     addr;
    word_t     wdata;
  } mem_req_t;

  // Decoded operation seen by memory and extension
  typedef struct packed {
    logic       wr_en;
    logic       rd_en;
    lane_mask_t lanes;
    mem_size_e  size;
    logic       is_unsigned;
    addr_t      addr;
    word_t      wdata;
  } mem_op_t;

  // One debug sample
  typedef struct packed {
    addr_t addr;
    word_t data;
  } dump_word_t;

  // Debug scan sequencer
  typedef enum logic [1:0] {
    DUMP_IDLE,
    DUMP_SCAN,
    DUMP_DRAIN
  } dump_state_e;

endpackage

// File: logic/mem_access_decode.sv
`timescale 1ns/1ps

module mem_access_decode (
  input  logic              i_clock,
  input  logic              i_arst_n,
  input  logic              i_enable,   // Pipeline hold when low
  input  mem_pkg::mem_req_t i_req,
  output mem_pkg::mem_op_t  o_op
);

  import mem_pkg::*;

  // Control bits, cleared by reset
  logic       wr_en_q;
  logic       rd_en_q;

  // Payload, no reset needed
  lane_mask_t lanes_q;
  mem_size_e  size_q;
  logic       is_unsigned_q;
  addr_t      addr_q;
  word_t      wdata_q;

  lane_mask_t req_lanes;

  // Size to byte lanes, low lanes only
  function automatic lane_mask_t size_to_lanes(input mem_size_e size);
    lane_mask_t mask;
    case (size)
      SIZE_BYTE: mask = 4'b0001;
      SIZE_HALF: mask = 4'b0011;
      default:   mask = 4'b1111;  // Word and reserved
    endcase
    return mask;
  endfunction

  assign req_lanes = size_to_lanes(i_req.size);

  // Strobes only for valid requests
  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_en_q <= 1'b0;
      rd_en_q <= 1'b0;
    end else if (i_enable) begin
      wr_en_q <= i_req.valid & i_req.write;
      rd_en_q <= i_req.valid & i_req.read;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_enable) begin
      lanes_q       <= req_lanes;
      size_q        <= i_req.size;         // Kept for the extension stage
      is_unsigned_q <= i_req.is_unsigned;
      addr_q        <= i_req.addr;
      wdata_q       <= i_req.wdata;
    end
  end

  assign o_op = '{
    wr_en:       wr_en_q,
    rd_en:       rd_en_q,
    lanes:       lanes_q,
    size:        size_q,
    is_unsigned: is_unsigned_q,
    addr:        addr_q,
    wdata:       wdata_q
  };

  // Execute stage must not ask for a load and a store at once
  a_req_one_dir: assert property (@(posedge i_clock) disable iff (!i_arst_n)
    (i_enable && i_req.valid) |-> !(i_req.write && i_req.read));

endmodule

// File: logic/data_memory.sv
`timescale 1ns/1ps

module data_memory (
  input  logic             i_clock,
  input  logic             i_enable,     // Pipeline hold, debug port ignores it
  input  mem_pkg::mem_op_t i_op,
  input  logic             i_dbg_rd_en,  // Debug unit strobe
  input  mem_pkg::addr_t   i_dbg_addr,   // Debug unit address
  output mem_pkg::word_t   o_rd_data,    // Zero-filled load word
  output mem_pkg::word_t   o_dbg_data    // Debug word, zero when idle
);

  import mem_pkg::*;

  word_t mem [MEM_DEPTH];  // 32 x 32 storage
  word_t rd_word;          // Masked view of the addressed word
  word_t rd_q;
  word_t dbg_q;

  // Power-up contents are zero
  initial begin
    for (int i = 0; i < MEM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // Lane-masked store, upper lanes untouched for byte and half
  always @(posedge i_clock) begin
    if (i_enable && i_op.wr_en) begin
      for (int l = 0; l < NB_LANES; l++) begin
        if (i_op.lanes[l]) begin
          mem[i_op.addr][l*8 +: 8] <= i_op.wdata[l*8 +: 8];
        end
      end
    end
  end

  // Unselected lanes read back as zero
  always_comb begin
    rd_word = '0;
    for (int l = 0; l < NB_LANES; l++) begin
      if (i_op.lanes[l]) begin
        rd_word[l*8 +: 8] = mem[i_op.addr][l*8 +: 8];
      end
    end
  end

  // Load data register, frozen while stalled
  always_ff @(posedge i_clock) begin
    if (i_enable && i_op.rd_en) begin
      rd_q <= rd_word;
    end
  end

  // Debug read keeps running while the core is halted
  always_ff @(posedge i_clock) begin
    if (i_dbg_rd_en) begin
      dbg_q <= mem[i_dbg_addr];
    end else begin
      dbg_q <= '0;
    end
  end

  assign o_rd_data  = rd_q;
  assign o_dbg_data = dbg_q;

  // Decode only ever produces byte, half or word masks
  a_lanes_legal: assert property (@(posedge i_clock)
    (i_enable && (i_op.wr_en || i_op.rd_en)) |->
      (i_op.lanes inside {4'b0001, 4'b0011, 4'b1111}));

endmodule

// File: logic/load_extend.sv
`timescale 1ns/1ps

module load_extend (
  input  logic             i_clock,
  input  logic             i_arst_n,
  input  logic             i_enable,
  input  mem_pkg::mem_op_t i_op,          // Same op the memory is reading
  input  mem_pkg::word_t   i_rd_data,     // Zero-filled word from memory
  output mem_pkg::word_t   o_load,
  output logic             o_load_valid
);

  import mem_pkg::*;

  logic      ld_valid_q;     // Load in flight, aligned with i_rd_data
  mem_size_e ld_size_q;
  logic      ld_unsigned_q;
  word_t     ext_word;

  // Capture load control on the memory read edge
  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ld_valid_q <= 1'b0;
    end else if (i_enable) begin
      ld_valid_q <= i_op.rd_en;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_enable) begin
      ld_size_q     <= i_op.size;
      ld_unsigned_q <= i_op.is_unsigned;
    end
  end

  // Upper lanes are already zero, only signed loads need work
  always_comb begin
    ext_word = i_rd_data;
    if (!ld_unsigned_q) begin
      case (ld_size_q)
        SIZE_BYTE: ext_word = {{24{i_rd_data[7]}}, i_rd_data[7:0]};
        SIZE_HALF: ext_word = {{16{i_rd_data[15]}}, i_rd_data[15:0]};
        default:   ext_word = i_rd_data;  // Word passes through
      endcase
    end
  end

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_load_valid <= 1'b0;
    end else if (i_enable) begin
      o_load_valid <= ld_valid_q;  // One enabled cycle per load
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_enable && ld_valid_q) begin
      o_load <= ext_word;
    end
  end

endmodule

// File: logic/debug_mem_reader.sv
`timescale 1ns/1ps

module debug_mem_reader (
  input  logic                i_clock,
  input  logic                i_arst_n,
  input  logic                i_dump_start,  // One-cycle request from debug unit
  input  mem_pkg::word_t      i_dbg_data,    // Returned one cycle after address
  output logic                o_dbg_rd_en,
  output mem_pkg::addr_t      o_dbg_addr,
  output mem_pkg::dump_word_t o_dump,
  output logic                o_dump_valid,
  output logic                o_dump_done
);

  import mem_pkg::*;

  dump_state_e state;
  dump_state_e state_next;
  addr_t       addr_cnt;   // Next address to issue
  logic        rd_q;       // Read issued last cycle
  addr_t       addr_q;     // Address of the word now on i_dbg_data

  // Scan, then wait for the last word to leave
  always_comb begin
    state_next = state;
    case (state)
      DUMP_IDLE: begin
        if (i_dump_start) state_next = DUMP_SCAN;
      end
      DUMP_SCAN: begin
        if (addr_cnt == addr_t'(MEM_DEPTH - 1)) state_next = DUMP_DRAIN;
      end
      DUMP_DRAIN: begin
        if (o_dump_valid && o_dump.addr == addr_t'(MEM_DEPTH - 1)) state_next = DUMP_IDLE;
      end
      default: state_next = DUMP_IDLE;
    endcase
  end

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state        <= DUMP_IDLE;
      addr_cnt     <= '0;
      rd_q         <= 1'b0;
      o_dump_valid <= 1'b0;
      o_dump_done  <= 1'b0;
    end else begin
      state <= state_next;
      if (state == DUMP_SCAN) begin
        addr_cnt <= addr_cnt + addr_t'(1);  // Wraps back to 0 after the last word
      end
      rd_q         <= o_dbg_rd_en;
      o_dump_valid <= rd_q;
      // Done follows the final word by one cycle
      o_dump_done  <= o_dump_valid && (o_dump.addr == addr_t'(MEM_DEPTH - 1));
    end
  end

  // Address tag travels alongside the memory read
  always_ff @(posedge i_clock) begin
    addr_q <= o_dbg_addr;
    if (rd_q) begin
      o_dump <= '{addr: addr_q, data: i_dbg_data};
    end
  end

  assign o_dbg_rd_en = (state == DUMP_SCAN);
  assign o_dbg_addr  = addr_cnt;

  a_done_after_data: assert property (@(posedge i_clock) disable iff (!i_arst_n)
    !(o_dump_done && o_dump_valid));

endmodule

// File: logic/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top (
  input  logic                i_clock,
  input  logic                i_arst_n,
  input  logic                i_enable,      // Holds all three stages
  input  mem_pkg::mem_req_t   i_req,
  input  logic                i_dump_start,
  output mem_pkg::word_t      o_load,
  output logic                o_load_valid,
  output mem_pkg::dump_word_t o_dump,
  output logic                o_dump_valid,
  output logic                o_dump_done
);

  import mem_pkg::*;

  mem_op_t op;         // Decoded request, shared by memory and extension
  word_t   rd_data;
  word_t   dbg_data;
  logic    dbg_rd_en;
  addr_t   dbg_addr;

  // Stage 1
  mem_access_decode u_decode (
    .i_clock  (i_clock),
    .i_arst_n (i_arst_n),
    .i_enable (i_enable),
    .i_req    (i_req),
    .o_op     (op)
  );

  // Stage 2, plus the debug read port
  data_memory u_memory (
    .i_clock     (i_clock),
    .i_enable    (i_enable),
    .i_op        (op),
    .i_dbg_rd_en (dbg_rd_en),
    .i_dbg_addr  (dbg_addr),
    .o_rd_data   (rd_data),
    .o_dbg_data  (dbg_data)
  );

  // Stage 3
  load_extend u_extend (
    .i_clock      (i_clock),
    .i_arst_n     (i_arst_n),
    .i_enable     (i_enable),
    .i_op         (op),
    .i_rd_data    (rd_data),
    .o_load       (o_load),
    .o_load_valid (o_load_valid)
  );

  // Runs independent of i_enable
  debug_mem_reader u_dump (
    .i_clock      (i_clock),
    .i_arst_n     (i_arst_n),
    .i_dump_start (i_dump_start),
    .i_dbg_data   (dbg_data),
    .o_dbg_rd_en  (dbg_rd_en),
    .o_dbg_addr   (dbg_addr),
    .o_dump       (o_dump),
    .o_dump_valid (o_dump_valid),
    .o_dump_done  (o_dump_done)
  );

endmodule

// File: tb/tb_mem_model.svh
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

word_t model_mem [MEM_DEPTH];  // Expected memory contents
word_t exp_q [$];              // Expected load results, oldest first

task automatic model_clear();
  for (int i = 0; i < MEM_DEPTH; i++) begin
    model_mem[i] = '0;         // Matches the power-up contents
  end
endtask

// Narrow stores replace the low lanes, the rest of the word stays
task automatic model_store(input addr_t addr, input mem_size_e size, input word_t data);
  case (size)
    SIZE_BYTE: model_mem[addr] = {model_mem[addr][31:8], data[7:0]};
    SIZE_HALF: model_mem[addr] = {model_mem[addr][31:16], data[15:0]};
    default:   model_mem[addr] = data;  // Word and reserved code
  endcase
endtask

// Zero-filled read, then sign extension when asked
function automatic word_t model_load(input addr_t addr, input mem_size_e size,
                                     input logic is_unsigned);
  logic signed [NB_DATA-1:0] s;
  word_t m;
  word_t v;
  m = model_mem[addr];
  v = m;
  if (size == SIZE_BYTE) begin
    s = $signed(m[7:0]);     // Widened with the sign of bit 7
    v = is_unsigned ? word_t'(m[7:0]) : word_t'(s);
  end else if (size == SIZE_HALF) begin
    s = $signed(m[15:0]);
    v = is_unsigned ? word_t'(m[15:0]) : word_t'(s);
  end
  return v;
endfunction

// Effect of one request that the DUT samples
task automatic model_apply(input mem_req_t req);
  if (req.valid && req.write) begin
    model_store(req.addr, req.size, req.wdata);
  end
  if (req.valid && req.read) begin
    exp_q.push_back(model_load(req.addr, req.size, req.is_unsigned));
  end
endtask

`endif

// File: tb/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;

  import mem_pkg::*;

  `include "tb_mem_model.svh"

  localparam int WAIT_LIMIT = 200;  // Cycles allowed for any one wait

  logic       i_clock;
  logic       i_arst_n;
  logic       i_enable;
  mem_req_t   i_req;
  logic       i_dump_start;
  word_t      o_load;
  logic       o_load_valid;
  dump_word_t o_dump;
  logic       o_dump_valid;
  logic       o_dump_done;

  logic [31:0] rng_state = 32'hdd30_f9a4;
  int          loads_seen = 0;
  logic        held;        // Next edge is a stalled one
  logic        held_valid;
  word_t       held_load;

  mem_stage_top dut (
    .i_clock (i_clock), .i_arst_n (i_arst_n), .i_enable (i_enable),
    .i_req (i_req), .i_dump_start (i_dump_start),
    .o_load (o_load), .o_load_valid (o_load_valid),
    .o_dump (o_dump), .o_dump_valid (o_dump_valid), .o_dump_done (o_dump_done)
  );

  always #2 i_clock = ~i_clock;  // 4 ns period

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_load(input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAIL %0t: load returned %h, expected %h", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_dump(input dump_word_t got, input dump_word_t exp);
    if (got !== exp) begin
      $display("FAIL %0t: dump gave addr %0d data %h, expected addr %0d data %h",
               $time, got.addr, got.data, exp.addr, exp.data);
      abort_run();
    end
  endtask

  function automatic mem_req_t make_req(input logic wr, input logic rd, input mem_size_e size,
                                        input logic uns, input addr_t addr, input word_t data);
    mem_req_t r;
    r.valid       = wr | rd;
    r.write       = wr;
    r.read        = rd;
    r.size        = size;
    r.is_unsigned = uns;
    r.addr        = addr;
    r.wdata       = data;
    return r;
  endfunction

  // DUT samples these at the next edge
  task automatic issue(input mem_req_t req, input logic en);
    @(posedge i_clock);
    i_req    <= req;
    i_enable <= en;
    if (en) model_apply(req);
  endtask

  task automatic drain_loads();
    int waited = 0;
    while (exp_q.size() != 0) begin
      issue('0, 1'b1);
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Timed out with %0d loads still outstanding", exp_q.size());
        abort_run();
      end
    end
  endtask

  // Each load result is consumed at an enabled edge
  always @(posedge i_clock) begin
    if (i_arst_n && i_enable && o_load_valid) begin
      if (exp_q.size() == 0) begin
        $display("A load result arrived with no load outstanding at %0t", $time);
        abort_run();
      end else begin
        check_load(o_load, exp_q.pop_front());
        loads_seen++;
      end
    end
  end

  // Stalled edge must leave the load output untouched
  always @(negedge i_clock) begin
    if (i_arst_n && held && (o_load_valid !== held_valid || o_load !== held_load)) begin
      $display("FAIL %0t: load output changed while the pipeline was held", $time);
      abort_run();
    end
    held       = i_arst_n && !i_enable;
    held_valid = o_load_valid;
    held_load  = o_load;
  end

  initial begin
    mem_req_t    r;
    addr_t       addrs [16];
    logic [31:0] x;
    dump_word_t  e;
    int          count;
    int          waited;
    model_clear();
    i_clock      = 1'b0;
    i_arst_n     = 1'b0;
    i_enable     = 1'b0;
    i_req        = '0;
    i_dump_start = 1'b0;
    repeat (4) @(posedge i_clock);
    i_arst_n <= 1'b1;
    for (int i = 0; i < 16; i++) begin  // Word stores followed by word loads
      addrs[i] = addr_t'(lcg_next() >> 20);
      issue(make_req(1'b1, 1'b0, SIZE_WORD, 1'b0, addrs[i], lcg_next()), 1'b1);
    end
    for (int i = 0; i < 16; i++) begin
      issue(make_req(1'b0, 1'b1, SIZE_WORD, 1'b0, addrs[i], '0), 1'b1);
    end
    // Narrow stores each read back whole by the very next request
    for (int i = 0; i < 16; i++) begin
      issue(make_req(1'b1, 1'b0, mem_size_e'(i % 2), 1'b0, addrs[i], lcg_next()), 1'b1);
      issue(make_req(1'b0, 1'b1, SIZE_WORD, 1'b0, addrs[i], '0), 1'b1);
    end
    for (int i = 0; i < 32; i++) begin  // Byte and half loads in both signedness modes
      issue(make_req(1'b0, 1'b1, mem_size_e'(i % 2), i[1], addrs[i % 16], '0), 1'b1);
    end
    for (int i = 0; i < 16; i++) begin  // Store then load of one address at random sizes
      x = lcg_next();
      issue(make_req(1'b1, 1'b0, mem_size_e'(x[31:30]), 1'b0, x[26:22], lcg_next()), 1'b1);
      issue(make_req(1'b0, 1'b1, mem_size_e'(x[29:28]), x[27], x[26:22], '0), 1'b1);
    end
    for (int i = 0; i < 400; i++) begin  // Mixed traffic with stalls
      x             = lcg_next();
      r.valid       = (x[31:30] != 2'b00);
      r.write       = r.valid ? x[29] : x[28];   // Invalid ones may carry junk strobes
      r.read        = r.valid ? !x[29] : x[27];
      r.size        = mem_size_e'(x[26:25]);
      r.is_unsigned = x[24];
      r.addr        = x[23:19];
      r.wdata       = lcg_next();
      issue(r, x[17:16] != 2'b00);
    end
    drain_loads();
    repeat (4) issue('0, 1'b1);  // Last stores commit
    issue('0, 1'b0);             // Core halted from here on
    i_dump_start <= 1'b1;
    count  = 0;
    waited = 0;
    while (count < MEM_DEPTH) begin
      @(posedge i_clock);
      i_dump_start <= (count == 10);  // Second start mid-scan
      if (o_dump_valid) begin
        e.addr = addr_t'(count);
        e.data = model_mem[count];
        check_dump(o_dump, e);
        count++;
      end else if (count != 0) begin
        $display("Dump words stopped after %0d of %0d", count, MEM_DEPTH);
        abort_run();
      end else begin
        waited++;
        if (waited > WAIT_LIMIT) begin
          $display("Timed out waiting for the first dump word");
          abort_run();
        end
      end
    end
    @(posedge i_clock);
    if (!o_dump_done || o_dump_valid) begin
      $display("No done pulse right after the last dump word");
      abort_run();
    end
    repeat (4) begin
      @(posedge i_clock);
      if (o_dump_done || o_dump_valid) begin
        $display("Dump outputs active after the scan finished");
        abort_run();
      end
    end
    if (loads_seen > 0 && exp_q.size() == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Load results missing, %0d checked", loads_seen);
      abort_run();
    end
  end

endmodule

// File: compile.f
+incdir+tb
logic/mem_pkg.sv
logic/mem_access_decode.sv
logic/data_memory.sv
logic/load_extend.sv
logic/debug_mem_reader.sv
logic/mem_stage_top.sv
tb/tb_mem_stage.sv
